//--- all.f
+incdir+hdl
hdl/core_pkg.sv
hdl/register_file.sv
hdl/issue_stage.sv
hdl/hazard_control.sv
hdl/mul_div_unit.sv
hdl/exec_stage.sv
hdl/exec_core.sv
test/tb_clock.sv
test/exec_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the exec_core testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        -f all.f --top-module exec_core_tb -o sim_exec_core; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_exec_core > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi
exit 0

//--- test/exec_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb import core_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        issue_valid;
    issue_t      issue;
    logic        issue_credit;
    commit_t     commit;

    logic [31:0] model_regs [32];
    logic        skip_next;    // Model side of the branch shadow
    result_t     exp_q [$];
    logic [31:0] lfsr;
    int          credits;
    int          sent = 0;
    int          cycles = 0;

    tb_clock clock_i (
        .clk (clk),
        .rst (rst)
    );

    exec_core dut_i (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_credit (issue_credit),
        .commit       (commit)
    );

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    // ############################################################
    // Reference model
    // ############################################################

    function automatic logic [31:0] ref_value(input alu_op_t op, input logic [31:0] a,
                                              input logic [31:0] b, input logic [11:0] imm);
        longint          ps;
        longint unsigned pu;
        int              sa;
        int              sb;
        sa = a;
        sb = b;
        case (op)
            ADD:  return a + b;
            SUB:  return a - b;
            AND:  return a & b;
            OR:   return a | b;
            XOR:  return a ^ b;
            SLT:  return (sa < sb) ? 32'd1 : 32'd0;
            ADDI: return a + {{20{imm[11]}}, imm};
            MUL, MULH: begin
                ps = longint'(sa) * longint'(sb);
                return (op == MUL) ? ps[31:0] : ps[63:32];
            end
            MULHSU: begin
                ps = longint'(sa) * longint'({32'd0, b});
                return ps[63:32];
            end
            MULHU: begin
                pu = {32'd0, a} * {32'd0, b};
                return pu[63:32];
            end
            DIV: begin
                if (b == 32'd0) return 32'hffff_ffff;
                if (a == 32'h8000_0000 && sb == -1) return a; // Signed overflow
                return sa / sb;
            end
            DIVU: return (b == 32'd0) ? 32'hffff_ffff : a / b;
            REM: begin
                if (b == 32'd0) return a;
                if (a == 32'h8000_0000 && sb == -1) return 32'd0;
                return sa % sb;
            end
            REMU:    return (b == 32'd0) ? a : a % b;
            default: return 32'd0;
        endcase
    endfunction

    task automatic model_step(input issue_t ins);
        result_t     r;
        logic [31:0] a;
        logic [31:0] b;
        if (skip_next) begin
            skip_next = 1'b0; // Discarded by the taken branch before it
        end else begin
            a = model_regs[ins.rs1];
            b = model_regs[ins.rs2];
            r.valid = 1'b1;
            r.rd = ins.rd;
            r.we = ins.we && (ins.op != BEQ);
            if (ins.op == BEQ || ins.rd == 5'd0) begin
                r.data = 32'd0;
            end else begin
                r.data = ref_value(ins.op, a, b, ins.imm);
            end
            if (ins.op == BEQ) begin
                skip_next = (a == b);
            end
            if (r.we && ins.rd != 5'd0) begin
                model_regs[ins.rd] = r.data;
            end
            exp_q.push_back(r);
        end
    endtask

    // ############################################################
    // Stimulus
    // ############################################################

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Waits for a held credit or one returned this cycle
    task automatic send_instr(input issue_t ins);
        @(negedge clk);
        while (credits == 0 && !issue_credit) begin
            @(negedge clk);
        end
        issue_valid = 1'b1;
        issue = ins;
        model_step(ins);
        sent++;
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic send_op(input alu_op_t op, input int rd, input int rs1, input int rs2,
                           input int imm);
        issue_t ins;
        ins.op  = op;
        ins.rd  = rd[4:0];
        ins.rs1 = rs1[4:0];
        ins.rs2 = rs2[4:0];
        ins.we  = 1'b1;
        ins.imm = imm[11:0];
        send_instr(ins);
    endtask

    task automatic drain_commits();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // ############################################################
    // Checkers
    // ############################################################

    always @(posedge clk) begin
        if (rst) begin
            credits <= 1;
        end else begin
            credits <= credits + int'(issue_credit) - int'(issue_valid);
        end
        cycles <= cycles + 1;
        if (cycles > sent * 6 + 50) begin
            abort_run($sformatf("Timeout after %0d cycles with %0d commits outstanding",
                                cycles, exp_q.size()));
        end
    end

    always @(negedge clk) begin : retire_check
        result_t want;
        if (!rst && commit.valid) begin
            assert (exp_q.size() != 0)
            else abort_run("A commit appeared with no instruction left to retire");
            if (exp_q.size() != 0) begin
                want = exp_q.pop_front();
                assert (commit.rd == want.rd && commit.we == want.we && commit.data == want.data)
                else abort_run($sformatf(
                    "Mismatch at %0t: commit rd=%0d we=%0b data=%h, expected rd=%0d we=%0b data=%h",
                    $time, commit.rd, commit.we, commit.data, want.rd, want.we, want.data));
            end
        end
    end

    // ############################################################
    // Directed tests
    // ############################################################

    task automatic alu_chain_test();
        send_op(ADDI, 1, 0, 0, 5);
        send_op(ADDI, 2, 1, 0, -12);  // Distance 1
        send_op(ADD, 3, 1, 2, 0);
        send_op(SUB, 4, 3, 1, 0);
        send_op(AND, 5, 4, 2, 0);     // x2 at distance 3
        idle_cycles(1);
        send_op(OR, 6, 5, 3, 0);
        send_op(XOR, 7, 6, 1, 0);
        idle_cycles(2);
        send_op(SLT, 8, 2, 1, 0);
        send_op(SLT, 9, 1, 2, 0);
        send_op(ADD, 10, 9, 8, 0);
        send_op(SLT, 11, 4, 4, 0);
        send_op(SUB, 12, 10, 7, 0);
        drain_commits();
    endtask

    task automatic x0_write_test();
        send_op(ADDI, 0, 1, 0, 7);
        send_op(ADD, 13, 0, 1, 0);    // Reads x0 right after the write
        send_op(ADD, 0, 1, 1, 0);
        send_op(SUB, 14, 1, 0, 0);
        send_op(OR, 15, 0, 0, 0);
        drain_commits();
    endtask

    task automatic mul_test();
        send_op(ADDI, 1, 0, 0, 1024);
        send_op(MUL, 2, 1, 1, 0);
        send_op(ADD, 3, 1, 1, 0);
        send_op(MUL, 4, 2, 3, 0);     // Most negative value
        send_op(ADDI, 5, 0, 0, -1);
        send_op(ADDI, 6, 4, 0, -1);   // Most positive value
        send_op(MULH, 7, 4, 4, 0);
        send_op(MULHSU, 8, 5, 4, 0);
        send_op(MULHU, 9, 5, 5, 0);
        send_op(MULH, 10, 4, 5, 0);
        send_op(MUL, 11, 6, 6, 0);
        send_op(ADD, 12, 11, 7, 0);
        send_op(MULHSU, 13, 4, 5, 0);
        drain_commits();
    endtask

    task automatic div_test();
        send_op(DIV, 14, 4, 5, 0);
        send_op(REM, 15, 4, 5, 0);
        send_op(DIV, 16, 6, 0, 0);    // Divide by zero
        send_op(DIVU, 17, 6, 0, 0);
        send_op(REM, 18, 6, 0, 0);
        send_op(REMU, 19, 4, 0, 0);
        send_op(ADDI, 20, 0, 0, -7);
        send_op(ADDI, 21, 0, 0, 5);
        send_op(DIV, 22, 20, 21, 0);
        send_op(REM, 23, 20, 21, 0);
        send_op(DIVU, 24, 20, 21, 0);
        send_op(REMU, 25, 20, 21, 0);
        send_op(SUB, 26, 25, 22, 0);
        drain_commits();
    endtask

    task automatic branch_test();
        send_op(ADDI, 1, 0, 0, 3);
        send_op(BEQ, 0, 1, 1, 0);
        send_op(ADDI, 2, 0, 0, 100);  // Killed while the branch is in E
        send_op(ADDI, 3, 0, 0, 200);
        send_op(BEQ, 0, 1, 3, 0);
        send_op(ADDI, 4, 0, 0, 1);
        send_op(BEQ, 0, 3, 3, 0);
        idle_cycles(4);
        send_op(ADDI, 5, 0, 0, 2);    // Late arrival in the shadow
        send_op(ADDI, 6, 5, 0, 1);
        send_op(BEQ, 0, 0, 0, 0);
        send_op(BEQ, 0, 0, 0, 0);
        send_op(ADDI, 7, 0, 0, 9);
        drain_commits();
        idle_cycles(3);
        assert (credits == 1 && !issue_credit)
        else abort_run($sformatf(
            "Mismatch at %0t: %0d credits and pulse %0b after branches, expected 1 and 0",
            $time, credits, issue_credit));
    endtask

    task automatic random_test();
        logic [31:0] op_bits;
        for (int n = 0; n < 40; n++) begin
            op_bits = rand_bits(4);
            send_op(alu_op_t'(op_bits[4:0]), int'(rand_bits(3)), int'(rand_bits(3)),
                    int'(rand_bits(3)), int'(rand_bits(12)));
            idle_cycles(int'(rand_bits(2)));
        end
        drain_commits();
    endtask

    initial begin
        issue_valid = 1'b0;
        issue = '0;
        skip_next = 1'b0;
        lfsr = 32'h3814_e5f2;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        wait (!rst);
        @(negedge clk);
        alu_chain_test();
        x0_write_test();
        mul_test();
        div_test();
        branch_test();
        random_test();
        idle_cycles(4);
        if (exp_q.size() == 0 && credits == 1) begin
            $display("test passed");
            $finish;
        end else begin
            abort_run($sformatf(
                "Mismatch at %0t: %0d retires left and %0d credits, expected 0 and 1",
                $time, exp_q.size(), credits));
        end
    end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    // Held over the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- hdl/exec_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module exec_core import core_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         issue_valid,
    input  wire issue_t issue,
    output logic        issue_credit,
    output commit_t     commit
);

    logic [4:0]            rd_addr1;
    logic [4:0]            rd_addr2;
    logic [`CORE_XLEN-1:0] rd_data1;
    logic [`CORE_XLEN-1:0] rd_data2;
    exec_t                 d_to_e;
    hazard_t               hz;
    logic [4:0]            e_rs1;
    logic [4:0]            e_rs2;
    alu_op_t               e_op;
    logic                  e_valid;
    logic                  branch_taken;
    result_t               m_res;
    result_t               w_res;

    assign commit = w_res;  // W register retires

    register_file rf_i (
        .clk(clk), .rst(rst), .raddr1(rd_addr1), .raddr2(rd_addr2),
        .rdata1(rd_data1), .rdata2(rd_data2), .wr(w_res)
    );

    issue_stage issue_i (
        .clk(clk), .rst(rst), .issue_valid(issue_valid), .issue(issue),
        .issue_credit(issue_credit), .hz(hz), .rd_addr1(rd_addr1), .rd_addr2(rd_addr2),
        .rd_data1(rd_data1), .rd_data2(rd_data2), .to_exec(d_to_e)
    );

    hazard_control hazard_i (
        .clk(clk), .rst(rst), .e_rs1(e_rs1), .e_rs2(e_rs2), .e_op(e_op),
        .e_valid(e_valid), .m_res(m_res), .w_res(w_res),
        .branch_taken(branch_taken), .hz(hz)
    );

    exec_stage exec_i (
        .clk(clk), .rst(rst), .from_issue(d_to_e), .hz(hz), .e_rs1(e_rs1),
        .e_rs2(e_rs2), .e_op(e_op), .e_valid(e_valid), .branch_taken(branch_taken),
        .m_res(m_res), .w_res(w_res)
    );

endmodule

`default_nettype wire

//--- hdl/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module exec_stage import core_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire exec_t   from_issue,
    input  wire hazard_t hz,
    output logic [4:0]   e_rs1,
    output logic [4:0]   e_rs2,
    output alu_op_t      e_op,
    output logic         e_valid,
    output logic         branch_taken,
    output result_t      m_res,
    output result_t      w_res
);

    exec_t                 e_q;
    logic                  e_first;   // First cycle of the op in E
    logic                  md_op;
    logic                  md_start;
    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;
    logic [`CORE_XLEN-1:0] imm_ext;
    logic [`CORE_XLEN-1:0] md_out;
    logic [`CORE_XLEN-1:0] alu_out;

    function automatic logic [`CORE_XLEN-1:0] fwd_mux(
        input logic [1:0]            sel,
        input logic [`CORE_XLEN-1:0] rf_val,
        input logic [`CORE_XLEN-1:0] m_val,
        input logic [`CORE_XLEN-1:0] w_val
    );
        case (sel)
            `FWD_MEM: return m_val;
            `FWD_WB:  return w_val;
            default:  return rf_val;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            e_q.valid <= 1'b0;
            e_first   <= 1'b0;
        end else begin
            e_first <= !hz.stall_e;
            if (!hz.stall_e) begin
                e_q <= from_issue;
            end
        end
    end

    assign e_rs1   = e_q.ins.rs1;
    assign e_rs2   = e_q.ins.rs2;
    assign e_op    = e_q.ins.op;
    assign e_valid = e_q.valid;

    assign op_a    = fwd_mux(hz.fwd1, e_q.rs1_data, m_res.data, w_res.data);
    assign op_b    = fwd_mux(hz.fwd2, e_q.rs2_data, m_res.data, w_res.data);
    assign imm_ext = {{(`CORE_XLEN-`CORE_IMM_W){e_q.ins.imm[`CORE_IMM_W-1]}}, e_q.ins.imm};

    assign md_op    = e_q.ins.op inside {MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU};
    assign md_start = e_q.valid && md_op && e_first; // Operands forwarded only on entry

    mul_div_unit md_i (
        .clk    (clk),
        .rst    (rst),
        .start  (md_start),
        .op     (e_q.ins.op),
        .a      (op_a),
        .b      (op_b),
        .result (md_out)
    );

    always_comb begin
        case (e_q.ins.op)
            ADD:     alu_out = op_a + op_b;
            SUB:     alu_out = op_a - op_b;
            AND:     alu_out = op_a & op_b;
            OR:      alu_out = op_a | op_b;
            XOR:     alu_out = op_a ^ op_b;
            SLT:     alu_out = {{(`CORE_XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            ADDI:    alu_out = op_a + imm_ext;
            BEQ:     alu_out = '0;
            default: alu_out = md_out; // Ready by the advancing cycle
        endcase
    end

    assign branch_taken = e_q.valid && (e_q.ins.op == BEQ) && (op_a == op_b);

    // ##########################################################
    // M and W registers
    // ##########################################################
    always_ff @(posedge clk) begin
        if (rst || hz.bubble_m) begin
            m_res.valid <= 1'b0;
        end else begin
            m_res.valid <= e_q.valid;
            m_res.rd    <= e_q.ins.rd;
            m_res.we    <= e_q.ins.we && (e_q.ins.op != BEQ);
            m_res.data  <= (e_q.ins.rd == 5'd0) ? '0 : alu_out;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            w_res.valid <= 1'b0;
        end else begin
            w_res <= m_res;
        end
    end

endmodule

`default_nettype wire

//--- hdl/mul_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module mul_div_unit import core_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   start,
    input  wire alu_op_t          op,
    input  wire [`CORE_XLEN-1:0]  a,
    input  wire [`CORE_XLEN-1:0]  b,
    output logic [`CORE_XLEN-1:0] result
);

    localparam int XL = `CORE_XLEN;

    alu_op_t         op_q;
    logic [XL-1:0]   a_q;
    logic [XL-1:0]   b_q;
    logic            busy;     // Operands held, result lands next edge
    logic [2*XL-1:0] a_sx;
    logic [2*XL-1:0] a_zx;
    logic [2*XL-1:0] b_sx;
    logic [2*XL-1:0] b_zx;
    logic [2*XL-1:0] prod_ss;
    logic [2*XL-1:0] prod_su;
    logic [2*XL-1:0] prod_uu;
    logic            div_zero;
    logic            div_ovf;
    logic [XL-1:0]   b_safe_s;
    logic [XL-1:0]   b_safe_u;
    logic [XL-1:0]   quo_s;
    logic [XL-1:0]   rem_s;
    logic [XL-1:0]   quo_u;
    logic [XL-1:0]   rem_u;
    logic [XL-1:0]   res_d;

    always_ff @(posedge clk) begin
        if (start) begin
            op_q <= op;
            a_q  <= a;
            b_q  <= b;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else begin
            busy <= start;
        end
    end

    // Double-width truncated products
    assign a_sx = {{XL{a_q[XL-1]}}, a_q};
    assign a_zx = {{XL{1'b0}}, a_q};
    assign b_sx = {{XL{b_q[XL-1]}}, b_q};
    assign b_zx = {{XL{1'b0}}, b_q};
    assign prod_ss = a_sx * b_sx;
    assign prod_su = a_sx * b_zx;
    assign prod_uu = a_zx * b_zx;

    assign div_zero = (b_q == '0);
    assign div_ovf  = (a_q == {1'b1, {(XL-1){1'b0}}}) && (b_q == '1);

    // Dividing by one on overflow yields quotient a, remainder zero
    assign b_safe_s = (div_zero || div_ovf) ? XL'(1) : b_q;
    assign b_safe_u = div_zero ? XL'(1) : b_q;
    assign quo_s = $signed(a_q) / $signed(b_safe_s);
    assign rem_s = $signed(a_q) % $signed(b_safe_s);
    assign quo_u = a_q / b_safe_u;
    assign rem_u = a_q % b_safe_u;

    always_comb begin
        case (op_q)
            MUL:     res_d = prod_ss[XL-1:0];
            MULH:    res_d = prod_ss[2*XL-1:XL];
            MULHSU:  res_d = prod_su[2*XL-1:XL];
            MULHU:   res_d = prod_uu[2*XL-1:XL];
            DIV:     res_d = div_zero ? '1 : quo_s;
            DIVU:    res_d = div_zero ? '1 : quo_u;
            REM:     res_d = div_zero ? a_q : rem_s;
            REMU:    res_d = div_zero ? a_q : rem_u;
            default: res_d = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            result <= res_d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/hazard_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module hazard_control import core_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire [4:0]    e_rs1,
    input  wire [4:0]    e_rs2,
    input  wire alu_op_t e_op,
    input  wire          e_valid,
    input  wire result_t m_res,
    input  wire result_t w_res,
    input  wire          branch_taken,
    output hazard_t      hz
);

    logic [2:0] cnt;
    logic [2:0] limit;
    logic       mc_op;
    logic       mc_stall;

    // ##########################################################
    // Data hazards
    // ##########################################################

    // M wins over W, x0 never forwarded
    function automatic logic [1:0] fwd_code(
        input logic [4:0] addr,
        input result_t    m,
        input result_t    w
    );
        if (addr == 5'd0) begin
            return `FWD_NORMAL;
        end
        if (m.valid && m.we && m.rd == addr) begin
            return `FWD_MEM;
        end
        if (w.valid && w.we && w.rd == addr) begin
            return `FWD_WB;
        end
        return `FWD_NORMAL;
    endfunction

    // ##########################################################
    // Multi-cycle stall window
    // ##########################################################

    assign mc_op = e_valid && (e_op inside {MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU});
    assign limit = (e_op inside {DIV, DIVU, REM, REMU}) ? `DIV_STALL : `MUL_STALL;
    assign mc_stall = mc_op && (cnt < limit);

    // Counts from the entry cycle, back to zero as the op advances
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= 3'd0;
        end else if (mc_stall) begin
            cnt <= cnt + 3'd1;
        end else begin
            cnt <= 3'd0;
        end
    end

    always_comb begin
        hz.stall_d  = mc_stall;
        hz.stall_e  = mc_stall;
        hz.bubble_m = mc_stall;
        hz.flush_d  = branch_taken; // Kills the shadow instruction
        hz.fwd1     = fwd_code(e_rs1, m_res, w_res);
        hz.fwd2     = fwd_code(e_rs2, m_res, w_res);
    end

endmodule

`default_nettype wire

//--- hdl/issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module issue_stage import core_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   issue_valid,
    input  wire issue_t           issue,
    output logic                  issue_credit,
    input  wire hazard_t          hz,
    output logic [4:0]            rd_addr1,
    output logic [4:0]            rd_addr2,
    input  wire [`CORE_XLEN-1:0]  rd_data1,
    input  wire [`CORE_XLEN-1:0]  rd_data2,
    output exec_t                 to_exec
);

    logic   d_valid;
    issue_t d_ins;
    logic   shadow;       // Taken branch found D empty
    logic   kill_arrival;
    logic   slot_free;

    // Arrival in the branch shadow is dropped on entry
    assign kill_arrival = issue_valid && (shadow || hz.flush_d);

    // Leaves for E or is dropped on arrival
    assign slot_free = (d_valid && !hz.stall_d) || kill_arrival;

    always_ff @(posedge clk) begin
        if (rst) begin
            d_valid <= 1'b0;
        end else if (issue_valid) begin
            d_valid <= !kill_arrival;
        end else if (!hz.stall_d) begin
            d_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            d_ins <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            shadow <= 1'b0;
        end else if (issue_valid) begin
            shadow <= 1'b0;
        end else if (hz.flush_d && !d_valid) begin
            shadow <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_credit <= 1'b0;
        end else begin
            issue_credit <= slot_free; // One pulse per freed slot
        end
    end

    assign rd_addr1 = d_ins.rs1;
    assign rd_addr2 = d_ins.rs2;

    always_comb begin
        to_exec.valid    = d_valid && !hz.flush_d;
        to_exec.ins      = d_ins;
        to_exec.rs1_data = rd_data1;
        to_exec.rs2_data = rd_data2;
    end

endmodule

`default_nettype wire

//--- hdl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module register_file import core_pkg::*; (
    input  wire                   clk,
    input  wire                   rst,
    input  wire [4:0]             raddr1,
    input  wire [4:0]             raddr2,
    output logic [`CORE_XLEN-1:0] rdata1,
    output logic [`CORE_XLEN-1:0] rdata2,
    input  wire result_t          wr
);

    logic [`CORE_XLEN-1:0] regs [32];
    logic                  wr_en;

    assign wr_en = wr.valid && wr.we && (wr.rd != 5'd0);

    // Architectural state starts from zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Write-first bypass, x0 hardwired
    assign rdata1 = (raddr1 == 5'd0) ? '0 :
                    (wr_en && wr.rd == raddr1) ? wr.data : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 :
                    (wr_en && wr.rd == raddr2) ? wr.data : regs[raddr2];

endmodule

`default_nettype wire

//--- hdl/core_pkg.sv
`default_nettype none

`include "core_defines.svh"

package core_pkg;

    typedef enum logic [4:0] {
        ADD    = 5'd0,  SUB   = 5'd1,  AND   = 5'd2,  OR     = 5'd3,
        XOR    = 5'd4,  SLT   = 5'd5,  ADDI  = 5'd6,  BEQ    = 5'd7,
        MUL    = 5'd8,  MULH  = 5'd9,  MULHSU = 5'd10, MULHU = 5'd11,
        DIV    = 5'd12, DIVU  = 5'd13, REM   = 5'd14, REMU   = 5'd15
    } alu_op_t;

    // Decoded instruction from the sender
    typedef struct packed {
        alu_op_t               op;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [4:0]            rd;
        logic                  we;
        logic [`CORE_IMM_W-1:0] imm;
    } issue_t;

    typedef struct packed {
        logic                  valid;
        issue_t                ins;
        logic [`CORE_XLEN-1:0] rs1_data;
        logic [`CORE_XLEN-1:0] rs2_data;
    } exec_t;

    typedef struct packed {
        logic                  valid;
        logic [4:0]            rd;
        logic                  we;
        logic [`CORE_XLEN-1:0] data;
    } result_t;

    typedef struct packed {
        logic       stall_d;
        logic       stall_e;
        logic       bubble_m;
        logic       flush_d;
        logic [1:0] fwd1;
        logic [1:0] fwd2;
    } hazard_t;

    typedef result_t commit_t; // Retire port at the top

endpackage

`default_nettype wire

//--- hdl/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// ##########################################################
// Datapath widths
// ##########################################################
`define CORE_XLEN   32
`define CORE_IMM_W  12    // Sign-extended in execute

// ##########################################################
// Forward selects for the E operands
// ##########################################################
`define FWD_NORMAL  2'b00 // Register file value
`define FWD_MEM     2'b01 // M-stage result
`define FWD_WB      2'b10 // W-stage result

// ##########################################################
// Stall lengths of multi-cycle ops
// ##########################################################
`define MUL_STALL   3'd2
`define DIV_STALL   3'd4  // Remainder shares the divider

`endif
